/* hdl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  // ====================
  // Basic types
  // ====================
  typedef logic [31:0] word_t;      // Data word, also used for PCs
  typedef logic [4:0]  reg_addr_t;  // Register number

  // ====================
  // Encodings
  // ====================
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,  // ALU ops selected by funct
    OP_BEQ   = 6'h04,
    OP_ADDIU = 6'h09,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B,
    OP_HALT  = 6'h3F   // Drains the pipe
  } opcode_e;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2A
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4   // Signed compare
  } alu_op_e;

  // Control bits that follow an instruction down the pipe
  typedef struct packed {
    logic reg_write;   // Writes dst in WB
    logic mem_read;    // Load
    logic mem_write;   // Store
    logic mem_to_reg;  // WB takes load data
    logic alu_src;     // Operand B is the immediate
    logic branch;      // BEQ
    logic halt;
    logic valid;       // Low for bubbles
  } ctrl_t;

  // ====================
  // Pipeline registers
  // ====================
  typedef struct packed {
    word_t next_pc;  // PC + 4
    word_t instr;    // Zero word is a bubble
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    alu_op_e   alu_op;
    word_t     next_pc;
    word_t     rd1;   // rs value from register file
    word_t     rd2;   // rt value from register file
    word_t     imm;   // Sign-extended
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dst;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     load_data;
    reg_addr_t dst;
  } mem_wb_t;

  // Result being written back, seen by forwarding and the register file
  typedef struct packed {
    reg_addr_t dst;
    logic      we;
    word_t     data;
  } fwd_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import mips_pkg::*; #(
  parameter int PC_W = 10
) (
  input  wire              i_clk,
  input  wire              i_rst_n,
  input  wire              i_stall,          // Hold PC and IF/ID
  input  wire              i_halt_fetch,     // Halt in decode
  input  wire              i_flush,          // Taken branch
  input  wire  word_t      i_branch_target,
  output logic [PC_W-1:0]  o_imem_addr,
  input  wire  word_t      i_imem_data,
  output if_id_t           o_if_id
);

  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc_plus4;
  logic            halted_q;  // Halt went past decode, fetch stays frozen
  logic            freeze;

  assign pc_plus4    = pc_q + PC_W'(4);
  assign freeze      = i_stall | i_halt_fetch | halted_q;
  assign o_imem_addr = pc_q;  // Word comes back this cycle

  // PC and halt flag
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q     <= '0;
      halted_q <= 1'b0;
    end else begin
      if (i_halt_fetch)
        halted_q <= 1'b1;
      if (i_flush)
        pc_q <= i_branch_target[PC_W-1:0];  // Redirect wins
      else if (!freeze)
        pc_q <= pc_plus4;
    end
  end

  // IF/ID register, a zero instruction is a bubble
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_if_id.instr <= '0;
    end else if (!i_stall) begin
      o_if_id.next_pc <= word_t'(pc_plus4);
      if (i_flush || i_halt_fetch || halted_q)
        o_if_id.instr <= '0;  // Squash wrong path or post-halt fetch
      else
        o_if_id.instr <= i_imem_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage import mips_pkg::*; (
  input  wire          i_clk,
  input  wire          i_rst_n,
  input  wire  if_id_t i_if_id,
  input  wire          i_flush,      // Taken branch in execute
  input  wire  fwd_t   i_wb,         // Register file write
  output id_ex_t       o_id_ex,
  output logic         o_stall,      // Load-use hazard
  output logic         o_halt_fetch
);

  word_t     regs [32];  // Entry 0 is never written
  word_t     instr;
  opcode_e   opcode;
  funct_e    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  word_t     imm;
  ctrl_t     ctrl;
  alu_op_e   alu_op;
  reg_addr_t dst;
  logic      uses_rt;    // rt is a source operand
  word_t     rd1;
  word_t     rd2;

  // ====================
  // Field extraction
  // ====================
  assign instr  = i_if_id.instr;
  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = {{16{instr[15]}}, instr[15:0]};  // Sign extend

  // Main decoder
  always_comb begin
    ctrl    = '0;
    alu_op  = ALU_ADD;
    dst     = rt;     // I-type default
    uses_rt = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        ctrl.valid     = 1'b1;
        ctrl.reg_write = 1'b1;
        dst            = rd;
        uses_rt        = 1'b1;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          default: ctrl   = '0;  // Unknown funct, no-op
        endcase
      end
      OP_ADDIU: begin
        ctrl.valid     = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      OP_LW: begin
        ctrl.valid      = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;  // Address = rs + imm
      end
      OP_SW: begin
        ctrl.valid     = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        uses_rt        = 1'b1;   // Store data
      end
      OP_BEQ: begin
        ctrl.valid  = 1'b1;
        ctrl.branch = 1'b1;
        alu_op      = ALU_SUB;
        uses_rt     = 1'b1;
      end
      OP_HALT: begin
        ctrl.valid = 1'b1;
        ctrl.halt  = 1'b1;
      end
      default: ctrl = '0;        // Invalid opcode, no-op
    endcase
    if (dst == '0)
      ctrl.reg_write = 1'b0;     // r0 stays zero
  end

  // ====================
  // Register file
  // ====================
  always_ff @(posedge i_clk) begin
    if (i_wb.we && i_wb.dst != '0)
      regs[i_wb.dst] <= i_wb.data;
  end

  // Write-before-read bypass, r0 reads zero
  function automatic word_t rf_read(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    if (i_wb.we && i_wb.dst == addr)
      return i_wb.data;
    return regs[addr];
  endfunction

  always_comb begin
    rd1 = rf_read(rs);
    rd2 = rf_read(rt);
  end

  // Load in execute feeding this instruction, rs is read by all but HALT
  assign o_stall = o_id_ex.ctrl.valid && o_id_ex.ctrl.mem_read && o_id_ex.rt != '0 &&
                   ctrl.valid && !ctrl.halt &&
                   (rs == o_id_ex.rt || (uses_rt && rt == o_id_ex.rt));

  assign o_halt_fetch = ctrl.valid & ctrl.halt & ~i_flush;

  // ID/EX register, bubble on stall or flush
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_id_ex.ctrl <= '0;
    end else begin
      o_id_ex.ctrl    <= (o_stall || i_flush) ? ctrl_t'('0) : ctrl;
      o_id_ex.alu_op  <= alu_op;
      o_id_ex.next_pc <= i_if_id.next_pc;
      o_id_ex.rd1     <= rd1;
      o_id_ex.rd2     <= rd2;
      o_id_ex.imm     <= imm;
      o_id_ex.rs      <= rs;
      o_id_ex.rt      <= rt;
      o_id_ex.dst     <= dst;
    end
  end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage import mips_pkg::*; (
  input  wire          i_clk,
  input  wire          i_rst_n,
  input  wire  id_ex_t i_id_ex,
  input  wire  fwd_t   i_wb,            // Writeback result
  output ex_mem_t      o_ex_mem,
  output fwd_t         o_mem_fwd,       // Our own EX/MEM result
  output logic         o_flush,         // One-cycle pulse
  output word_t        o_branch_target
);

  word_t op_a;     // Forwarded rs
  word_t fwd_b;    // Forwarded rt, also store data
  word_t op_b;
  word_t alu_res;

  // ====================
  // Forwarding
  // ====================
  // MEM result is newer than WB, so it wins
  function automatic word_t fwd_sel(input reg_addr_t src, input word_t rf_val,
                                    input fwd_t mem, input fwd_t wb);
    if (src == '0)
      return '0;
    if (mem.we && mem.dst == src)
      return mem.data;
    if (wb.we && wb.dst == src)
      return wb.data;
    return rf_val;
  endfunction

  // Loads in MEM have no data yet, load-use stall covers them
  assign o_mem_fwd = '{
    dst:  o_ex_mem.dst,
    we:   o_ex_mem.ctrl.valid & o_ex_mem.ctrl.reg_write & ~o_ex_mem.ctrl.mem_read,
    data: o_ex_mem.alu_result
  };

  assign op_a  = fwd_sel(i_id_ex.rs, i_id_ex.rd1, o_mem_fwd, i_wb);
  assign fwd_b = fwd_sel(i_id_ex.rt, i_id_ex.rd2, o_mem_fwd, i_wb);
  assign op_b  = i_id_ex.ctrl.alu_src ? i_id_ex.imm : fwd_b;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (i_id_ex.alu_op)
      ALU_ADD: alu_res = op_a + op_b;
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      default: alu_res = '0;
    endcase
  end

  // Branch resolves here, not-taken is the fetch default
  assign o_branch_target = i_id_ex.next_pc + {i_id_ex.imm[29:0], 2'b00};
  assign o_flush = i_id_ex.ctrl.valid & i_id_ex.ctrl.branch & (op_a == fwd_b);

  // EX/MEM register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ex_mem.ctrl <= '0;
    end else begin
      o_ex_mem.ctrl       <= i_id_ex.ctrl;
      o_ex_mem.alu_result <= alu_res;
      o_ex_mem.store_data <= fwd_b;        // SW data after forwarding
      o_ex_mem.dst        <= i_id_ex.dst;
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_wb_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage import mips_pkg::*; (
  input  wire           i_clk,
  input  wire           i_rst_n,
  input  wire  ex_mem_t i_ex_mem,
  output word_t         o_dmem_addr,   // Word address
  output logic          o_dmem_we,
  output word_t         o_dmem_wdata,
  input  wire  word_t   i_dmem_rdata,  // Same-cycle read data
  output fwd_t          o_wb,
  output logic          o_wb_valid,
  output reg_addr_t     o_wb_reg,
  output word_t         o_wb_data,
  output logic          o_halt
);

  mem_wb_t mem_wb_q;
  word_t   wb_data;
  logic    halt_now;  // Halt is in WB this cycle
  logic    halt_q;

  // ====================
  // Memory access
  // ====================
  assign o_dmem_addr  = {2'b00, i_ex_mem.alu_result[31:2]};  // Drop byte offset
  assign o_dmem_we    = i_ex_mem.ctrl.valid & i_ex_mem.ctrl.mem_write;
  assign o_dmem_wdata = i_ex_mem.store_data;

  // MEM/WB register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mem_wb_q.ctrl <= '0;
    end else begin
      mem_wb_q <= '{
        ctrl:       i_ex_mem.ctrl,
        alu_result: i_ex_mem.alu_result,
        load_data:  i_dmem_rdata,
        dst:        i_ex_mem.dst
      };
    end
  end

  // ====================
  // Writeback
  // ====================
  assign wb_data = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
  assign o_wb = '{
    dst:  mem_wb_q.dst,
    we:   mem_wb_q.ctrl.valid & mem_wb_q.ctrl.reg_write,
    data: wb_data
  };

  assign o_wb_valid = o_wb.we;    // Retire strobe
  assign o_wb_reg   = o_wb.dst;
  assign o_wb_data  = o_wb.data;

  // Halt rises in WB and sticks
  assign halt_now = mem_wb_q.ctrl.valid & mem_wb_q.ctrl.halt;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      halt_q <= 1'b0;
    else if (halt_now)
      halt_q <= 1'b1;
  end

  assign o_halt = halt_q | halt_now;

endmodule

`default_nettype wire

/* hdl/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_core import mips_pkg::*; #(
  parameter int PC_W = 10  // Instruction address width in bytes
) (
  input  wire              i_clk,
  input  wire              i_rst_n,
  // Instruction port answers in the same cycle
  output logic [PC_W-1:0]  o_imem_addr,
  input  wire  word_t      i_imem_data,
  // Word-addressed data port
  output word_t            o_dmem_addr,
  output logic             o_dmem_we,
  output word_t            o_dmem_wdata,
  input  wire  word_t      i_dmem_rdata,
  // Retire strobe
  output logic             o_wb_valid,
  output reg_addr_t        o_wb_reg,
  output word_t            o_wb_data,
  output logic             o_halt       // Sticky until reset
);

  // ====================
  // Inter-stage wiring
  // ====================
  if_id_t  if_id;          // Fetch -> decode
  id_ex_t  id_ex;          // Decode -> execute
  ex_mem_t ex_mem;         // Execute -> memory
  fwd_t    wb;             // Writeback result for regfile and forwarding
  logic    stall;          // One-cycle load-use hold
  logic    halt_fetch;     // Halt sitting in decode
  logic    flush;          // Taken branch in execute
  word_t   branch_target;

  fetch_stage #(
    .PC_W (PC_W)
  ) u_fetch (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_stall         (stall),
    .i_halt_fetch    (halt_fetch),
    .i_flush         (flush),
    .i_branch_target (branch_target),
    .o_imem_addr     (o_imem_addr),
    .i_imem_data     (i_imem_data),
    .o_if_id         (if_id)
  );

  decode_stage u_decode (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_if_id      (if_id),
    .i_flush      (flush),
    .i_wb         (wb),
    .o_id_ex      (id_ex),
    .o_stall      (stall),
    .o_halt_fetch (halt_fetch)
  );

  execute_stage u_execute (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_id_ex         (id_ex),
    .i_wb            (wb),
    .o_ex_mem        (ex_mem),
    .o_mem_fwd       (),
    .o_flush         (flush),
    .o_branch_target (branch_target)
  );

  mem_wb_stage u_mem_wb (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_ex_mem     (ex_mem),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .i_dmem_rdata (i_dmem_rdata),
    .o_wb         (wb),
    .o_wb_valid   (o_wb_valid),
    .o_wb_reg     (o_wb_reg),
    .o_wb_data    (o_wb_data),
    .o_halt       (o_halt)
  );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 8
) (
  output logic o_clk
);

  initial o_clk = 1'b0;                 // Starts low, first rise at half period
  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* dv/mips_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_asserts (
  input wire i_clk,
  input wire i_rst_n,
  input wire i_dmem_we,   // Data port write strobe
  input wire i_halt,      // Sticky halt
  input wire i_wb_valid   // Retire strobe
);

  // A halted core must not touch memory
  store_while_halted: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(i_dmem_we && i_halt)
  ) else $error("data write while o_halt is high");

  // Halt holds until reset
  halt_sticky: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_halt |=> i_halt
  ) else $error("o_halt fell without a reset");

  // No retire inside reset
  quiet_in_reset: assert property (
    @(posedge i_clk) !i_rst_n |-> !i_wb_valid
  ) else $error("o_wb_valid high while reset is asserted");

endmodule

bind mips_core mips_asserts u_asserts (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_dmem_we  (o_dmem_we),
  .i_halt     (o_halt),
  .i_wb_valid (o_wb_valid)
);

`default_nettype wire

/* dv/tb_mips.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips import mips_pkg::*; ();

  localparam int PC_W         = 10;
  localparam int IMEM_AW      = PC_W - 2;           // Word index bits
  localparam int IMEM_WORDS   = 1 << IMEM_AW;
  localparam int NUM_PROGS    = 12;
  localparam int BODY_LEN     = 40;                 // Random instructions per program
  localparam int PROG_LEN     = 7 + BODY_LEN + 1;   // Setup, body, HALT
  localparam int RESET_CYCLES = 10;
  localparam int CYCLE_NS     = 8;
  localparam int RUN_LIMIT    = 4 * PROG_LEN;       // Worst case about 3 cycles each
  localparam int DRAIN_CYCLES = 8;                  // Quiet window after halt
  localparam int WATCHDOG_NS  = 20 * PROG_LEN * NUM_PROGS * CYCLE_NS;

  // Expected architectural events
  typedef struct packed {
    reg_addr_t dst;
    word_t     data;
  } retire_t;

  typedef struct packed {
    logic [3:0] addr;  // Data word index
    word_t      data;
  } store_t;

  logic            clk;
  logic            rst_n;
  logic [PC_W-1:0] imem_addr;
  word_t           imem_data;
  word_t           dmem_addr;
  logic            dmem_we;
  word_t           dmem_wdata;
  word_t           dmem_rdata;
  logic            wb_valid;
  reg_addr_t       wb_reg;
  word_t           wb_data;
  logic            halt;

  word_t   imem [IMEM_WORDS];
  word_t   dmem [16];
  word_t   model_regs [32];
  word_t   model_mem [16];
  retire_t exp_retires [$];
  store_t  exp_stores [$];

  logic [31:0] seed;
  logic        halt_seen;  // o_halt observed since last reset
  int          n_checks;
  int          n_errors;
  int          n_retired;
  int          n_stored;

  tb_clock #(.PERIOD_NS(CYCLE_NS)) u_clock (.o_clk(clk));

  mips_core #(.PC_W(PC_W)) dut0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_wb_valid   (wb_valid),
    .o_wb_reg     (wb_reg),
    .o_wb_data    (wb_data),
    .o_halt       (halt)
  );

  // Both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[PC_W-1:2]];
  assign dmem_rdata = dmem[dmem_addr[3:0]];

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(input int n);
    seed = xorshift(seed);
    return int'(seed % 32'(n));
  endfunction

  function automatic word_t enc_r(input funct_e fn, input reg_addr_t rd, input reg_addr_t rs,
                                  input reg_addr_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_i(input opcode_e op, input reg_addr_t rt, input reg_addr_t rs,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
      n_errors++;
    end
  endtask

  task automatic fill_memories();
    int w;
    for (w = 0; w < IMEM_WORDS; w++)
      imem[IMEM_AW'(w)] = {OP_HALT, 26'(w)};  // Stray fetch stops the core
    for (w = 0; w < 16; w++)
      dmem[4'(w)] = 32'hd0d0_0000 | 32'(w);
  endtask

  // ====================
  // Program generator
  // ====================
  task automatic gen_program();
    int        idx;
    int        off;
    reg_addr_t d;
    reg_addr_t s;
    reg_addr_t t;
    funct_e    fn;

    fill_memories();
    for (idx = 0; idx < 16; idx++) begin
      dmem[4'(idx)]      = word_t'(rand_below(16));  // Small values give more BEQ hits
      model_mem[4'(idx)] = dmem[4'(idx)];
    end
    for (idx = 0; idx < 7; idx++)                   // r1..r7 get known values
      imem[IMEM_AW'(idx)] = enc_i(OP_ADDIU, 5'(idx + 1), 5'd0, 16'(rand_below(8)));
    for (idx = 7; idx < PROG_LEN - 1; idx++) begin
      d = 5'(rand_below(7) + 1);
      s = 5'(rand_below(7) + 1);
      t = 5'(rand_below(7) + 1);
      case (rand_below(10))
        0, 1, 2, 3: begin
          case (rand_below(5))
            0:       fn = FN_ADDU;
            1:       fn = FN_SUBU;
            2:       fn = FN_AND;
            3:       fn = FN_OR;
            default: fn = FN_SLT;
          endcase
          imem[IMEM_AW'(idx)] = enc_r(fn, d, s, t);
        end
        4: imem[IMEM_AW'(idx)] = enc_i(OP_ADDIU, d, s, 16'(rand_below(12) - 4));
        5, 6: imem[IMEM_AW'(idx)] = enc_i(OP_LW, d, 5'd0, 16'(rand_below(16) * 4));
        7: imem[IMEM_AW'(idx)] = enc_i(OP_SW, t, 5'd0, 16'(rand_below(16) * 4));
        default: begin
          // Forward offsets that stop at HALT
          off = rand_below((PROG_LEN - 1 - idx < 4) ? PROG_LEN - 1 - idx : 4);
          if (rand_below(2) == 0)
            t = s;                                  // Always taken
          imem[IMEM_AW'(idx)] = enc_i(OP_BEQ, t, s, 16'(off));
        end
      endcase
    end
    imem[IMEM_AW'(PROG_LEN - 1)] = {OP_HALT, 26'd0};
  endtask

  // ====================
  // Reference model
  // ====================
  task automatic model_write(input reg_addr_t dst, input word_t value);
    retire_t r;
    if (dst != 5'd0) begin                          // r0 never retires
      model_regs[dst] = value;
      r.dst  = dst;
      r.data = value;
      exp_retires.push_back(r);
    end
  endtask

  task automatic run_model(output int n_taken, output int stop_pc);
    int        pc;
    int        r;
    word_t     ins;
    word_t     a;
    word_t     b;
    word_t     imm;
    word_t     addr;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    store_t    st;
    logic      done;

    n_taken = 0;
    pc      = 0;
    done    = 1'b0;
    exp_retires.delete();
    exp_stores.delete();
    for (r = 0; r < 32; r++)
      model_regs[5'(r)] = 32'd0;
    while (!done) begin
      ins = imem[IMEM_AW'(pc)];
      rs  = ins[25:21];
      rt  = ins[20:16];
      rd  = ins[15:11];
      imm = {{16{ins[15]}}, ins[15:0]};
      a   = (rs == 5'd0) ? 32'd0 : model_regs[rs];
      b   = (rt == 5'd0) ? 32'd0 : model_regs[rt];
      pc  = pc + 1;                                 // Index of PC + 4
      case (ins[31:26])
        OP_RTYPE: begin
          case (ins[5:0])
            FN_ADDU: model_write(rd, a + b);
            FN_SUBU: model_write(rd, a - b);
            FN_AND:  model_write(rd, a & b);
            FN_OR:   model_write(rd, a | b);
            FN_SLT:  model_write(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            default: ;
          endcase
        end
        OP_ADDIU: model_write(rt, a + imm);
        OP_LW: begin
          addr = a + imm;
          model_write(rt, model_mem[addr[5:2]]);
        end
        OP_SW: begin
          addr = a + imm;
          model_mem[addr[5:2]] = b;
          st.addr = addr[5:2];
          st.data = b;
          exp_stores.push_back(st);
        end
        OP_BEQ: begin
          if (a == b) begin
            pc = pc + int'(imm);                    // Offset in words
            n_taken++;
          end
        end
        default: done = 1'b1;                       // HALT
      endcase
    end
    stop_pc = pc * 4;                               // Byte address after the HALT
  endtask

  // ====================
  // Monitor
  // ====================
  // Retires and stores observed at the falling edge
  always @(negedge clk) begin
    retire_t exp_r;
    store_t  exp_s;
    if (rst_n) begin
      if (wb_valid) begin
        n_retired++;
        if (halt_seen) begin
          $display("Retire of r%0d after the core halted", wb_reg);
          n_errors++;
        end else if (exp_retires.size() == 0) begin
          $display("Retire of r%0d that the model does not expect", wb_reg);
          n_errors++;
        end else begin
          exp_r = exp_retires.pop_front();
          check("o_wb_reg", 32'(wb_reg), 32'(exp_r.dst));
          check("o_wb_data", wb_data, exp_r.data);
        end
      end
      if (dmem_we) begin
        n_stored++;
        if (halt_seen || exp_stores.size() == 0) begin
          $display("Store to word %0h that the model does not expect", dmem_addr);
          n_errors++;
        end else begin
          exp_s = exp_stores.pop_front();
          check("o_dmem_addr", dmem_addr, 32'(exp_s.addr));
          check("o_dmem_wdata", dmem_wdata, exp_s.data);
        end
        dmem[dmem_addr[3:0]] = dmem_wdata;
      end
      if (halt)
        halt_seen = 1'b1;
    end
  end

  // ====================
  // Test sequence
  // ====================
  task automatic run_program(input int prog);
    int taken;
    int stop_pc;
    int cycles;
    int errs_before;
    int n_exp_ret;
    int n_exp_st;

    @(posedge clk);
    #1;
    rst_n       = 1'b0;
    halt_seen   = 1'b0;
    n_retired   = 0;
    n_stored    = 0;
    errs_before = n_errors;
    gen_program();                                  // Loaded while in reset
    run_model(taken, stop_pc);
    n_exp_ret = exp_retires.size();
    n_exp_st  = exp_stores.size();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    cycles = 0;
    while (!halt_seen && cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!halt_seen) begin
      $display("Program %0d did not raise o_halt within %0d cycles", prog, RUN_LIMIT);
      n_errors++;
    end
    repeat (DRAIN_CYCLES) @(negedge clk);          // Must stay quiet
    check("o_halt", 32'(halt), 32'd1);
    check("o_imem_addr", 32'(imem_addr), 32'(stop_pc));  // Fetch frozen past HALT
    if (exp_retires.size() != 0) begin
      $display("Program %0d is missing %0d retires", prog, exp_retires.size());
      n_errors++;
    end
    if (exp_stores.size() != 0) begin
      $display("Program %0d is missing %0d stores", prog, exp_stores.size());
      n_errors++;
    end
    $display("program %2d: retires %0d/%0d, stores %0d/%0d, taken %0d, cycles %0d, %s",
             prog, n_retired, n_exp_ret, n_stored, n_exp_st, taken, cycles,
             (n_errors == errs_before) ? "ok" : "with errors");
  endtask

  initial begin
    int prog;
    rst_n     = 1'b0;
    seed      = 32'hb9f;
    halt_seen = 1'b0;
    n_checks  = 0;
    n_errors  = 0;
    n_retired = 0;
    n_stored  = 0;
    fill_memories();
    for (prog = 0; prog < NUM_PROGS; prog++)
      run_program(prog);
    $display("programs %0d, checks %0d, errors %0d", NUM_PROGS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per instruction over all programs
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/mips_core.sv
dv/tb_clock.sv
dv/mips_asserts.sv
dv/tb_mips.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_mips into run.log and check the pass message"
	@echo "  clean  remove obj_dir and run.log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_mips -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_mips | tee run.log
	@grep -q "TEST PASSED" run.log || (echo "Simulation did not pass, see run.log"; exit 1)

clean:
	rm -rf obj_dir run.log
